// ==== source/gpuMemPkg.sv ====
`default_nettype none

package gpuMemPkg;

	// -------------------------------------------------------------------------
	// Bus side types
	// -------------------------------------------------------------------------
	typedef logic [19:0] busAdrT;	// Byte address, 1 MB of VRAM
	typedef logic [31:0] busDataT;	// One bus beat
	typedef logic [2:0]  beatCntT;	// Beats minus one
	typedef logic [3:0]  beatSelT;	// Byte enables

	// Cache side addresses
	typedef logic [16:0] texLineAdrT;	// 8-byte texture line
	typedef logic [14:0] clutBlockAdrT;	// 32-byte CLUT block
	typedef logic [14:0] blockAdrT;	// 32-byte block of a command

	typedef logic [15:0] pixelT;
	typedef logic [55:0] memCmdT;	// Op 2..0, pair 6..4, block 21..7, valid 23..22
	typedef logic [63:0] texDataT;	// Two beats, second one high
	typedef logic [2:0]  clutIndexT;

	// -------------------------------------------------------------------------
	// Encodings
	// -------------------------------------------------------------------------
	typedef enum logic [2:0] {
		cmdNone      = 3'd0,
		cmdPixelPair = 3'd1,
		cmdFill      = 3'd2
	} cmdOpT;

	typedef enum logic [1:0] {
		kindClut,
		kindTex,
		kindPixelPair,
		kindFill
	} burstKindT;

	typedef enum logic [1:0] {seqIdle, seqWaitAck, seqBeats} seqStateT;

	// Burst lengths, beats minus one
	localparam beatCntT texBeats  = 3'd1;
	localparam beatCntT clutBeats = 3'd7;
	localparam beatCntT fillBeats = 3'd7;
	localparam beatCntT pairBeats = 3'd0;

	localparam int beatBytes    = 4;
	localparam int texLineShift = 3;	// Line number to byte address
	localparam int blockShift   = 5;	// Block number to byte address

endpackage

`default_nettype wire

// ==== source/burstIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Granted burst, picker to sequencer
interface burstIf import gpuMemPkg::*; ();
	logic      grant;	// One cycle, only while idle
	logic      idle;	// Sequencer can take a burst
	burstKindT kind;
	logic      sideR;	// Right requester won
	busAdrT    baseAdr;	// Byte address of beat 0
	beatCntT   beats;
	pixelT     pixL;
	pixelT     pixR;
	beatSelT   pairSel;	// Write enables for every beat

	modport picker (
		output grant, kind, sideR, baseAdr, beats, pixL, pixR, pairSel,
		input  idle
	);

	modport seq (
		input  grant, kind, sideR, baseAdr, beats, pixL, pixR, pairSel,
		output idle
	);
endinterface

`default_nettype wire

// ==== source/beatIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Acked read beats, sequencer to router, no back-pressure
interface beatIf import gpuMemPkg::*; ();
	logic      beatValid;	// Read beat acked this cycle
	burstKindT kind;
	logic      sideR;
	busAdrT    baseAdr;	// Burst base, gives the texture line
	beatCntT   beatIdx;	// 0 for the first beat
	logic      lastBeat;
	busDataT   data;	// Straight from dat_i

	modport seq (
		output beatValid, kind, sideR, baseAdr, beatIdx, lastBeat, data
	);

	modport router (
		input  beatValid, kind, sideR, baseAdr, beatIdx, lastBeat, data
	);
endinterface

`default_nettype wire

// ==== source/requestPicker.sv ====
`timescale 1ns/1ps
`default_nettype none

module requestPicker import gpuMemPkg::*; (
	input  logic         gpuClk,
	input  logic         resetX,
	input  memCmdT       memCmd_i,
	input  logic         texReqL_i,
	input  texLineAdrT   texAdrL_i,
	input  logic         texReqR_i,
	input  texLineAdrT   texAdrR_i,
	input  logic         clutReqL_i,
	input  clutBlockAdrT clutAdrL_i,
	input  logic         clutReqR_i,
	input  clutBlockAdrT clutAdrR_i,
	output logic         cmdReady_o,
	burstIf.picker       burst
);

	cmdOpT      cmdOp;
	blockAdrT   cmdBlock;
	logic [2:0] cmdPairId;	// Word inside the block
	logic [1:0] cmdValidPair;	// Bit 0 left pixel, bit 1 right
	pixelT      cmdPixL;
	pixelT      cmdPixR;
	busAdrT     blockBase;
	logic       cmdValid;
	logic       cacheReq;
	logic       grantQ;	// Set on grant, cleared once idle again

	// Command word fields
	assign cmdOp        = cmdOpT'(memCmd_i[2:0]);
	assign cmdPairId    = memCmd_i[6:4];
	assign cmdBlock     = memCmd_i[21:7];
	assign cmdValidPair = memCmd_i[23:22];
	assign cmdPixR      = memCmd_i[39:24];
	assign cmdPixL      = memCmd_i[55:40];
	assign blockBase    = busAdrT'(cmdBlock) << blockShift;

	assign cmdValid = cmdOp != cmdNone;
	assign cacheReq = clutReqL_i | clutReqR_i | texReqL_i | texReqR_i;

	// Cache requests wait out the first idle cycle, their done pulse is still on its way
	assign burst.grant = burst.idle & (cmdValid | (cacheReq & ~grantQ));
	assign cmdReady_o  = burst.idle;

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			grantQ <= 1'b0;
		end else if (burst.grant) begin
			grantQ <= 1'b1;
		end else if (burst.idle) begin
			grantQ <= 1'b0;
		end
	end

	// Descriptor of the winner, command > CLUT > texture, left before right
	always_comb begin
		burst.kind    = kindTex;	// Left texture unless overridden
		burst.sideR   = 1'b0;
		burst.baseAdr = busAdrT'(texAdrL_i) << texLineShift;
		burst.beats   = texBeats;
		burst.pixL    = cmdPixL;
		burst.pixR    = cmdPixR;
		burst.pairSel = '1;
		if (cmdValid) begin
			if (cmdOp == cmdFill) begin
				burst.kind    = kindFill;
				burst.baseAdr = blockBase;
				burst.beats   = fillBeats;
				burst.pixR    = cmdPixL;	// Left pixel twice per word
			end else begin
				burst.kind    = kindPixelPair;
				burst.baseAdr = blockBase | busAdrT'(cmdPairId * beatBytes);	// Pair id is the word
				burst.beats   = pairBeats;
				burst.pairSel = {{2{cmdValidPair[1]}}, {2{cmdValidPair[0]}}};
			end
		end else if (clutReqL_i) begin
			burst.kind    = kindClut;
			burst.baseAdr = busAdrT'(clutAdrL_i) << blockShift;
			burst.beats   = clutBeats;
		end else if (clutReqR_i) begin
			burst.kind    = kindClut;
			burst.sideR   = 1'b1;
			burst.baseAdr = busAdrT'(clutAdrR_i) << blockShift;
			burst.beats   = clutBeats;
		end else if (!texReqL_i) begin
			burst.sideR   = 1'b1;	// Right texture
			burst.baseAdr = busAdrT'(texAdrR_i) << texLineShift;
		end
	end

endmodule

`default_nettype wire

// ==== source/burstSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstSequencer import gpuMemPkg::*; (
	input  logic    gpuClk,
	input  logic    resetX,
	burstIf.seq     burst,
	beatIf.seq      beat,
	output logic    req_o,
	output busAdrT  adr_o,
	output beatCntT cnt_o,
	output logic    wrt_o,
	output busDataT dat_o,
	output beatSelT sel_o,
	input  logic    ack_i,
	input  busDataT dat_i,
	output logic    busy_o
);

	seqStateT  state;
	beatCntT   beatNum;	// Beat acked in this cycle

	// Latched descriptor
	burstKindT kindQ;
	logic      sideQ;
	busAdrT    baseQ;
	beatCntT   beatsQ;
	pixelT     pixLQ;
	pixelT     pixRQ;
	beatSelT   selQ;

	logic      isWrite;
	logic      lastBeat;

	assign isWrite    = (kindQ == kindFill) || (kindQ == kindPixelPair);
	assign lastBeat   = beatNum == beatsQ;
	assign burst.idle = state == seqIdle;

	// -------------------------------------------------------------------------
	// Burst FSM
	// -------------------------------------------------------------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			state   <= seqIdle;
			beatNum <= '0;
		end else begin
			case (state)
				seqIdle: begin
					beatNum <= '0;
					if (burst.grant) begin
						state <= seqWaitAck;	// req_o up next cycle
					end
				end
				seqWaitAck: begin	// Slave may stall here
					if (ack_i) begin
						if (lastBeat) begin
							state <= seqIdle;	// Single beat burst
						end else begin
							state   <= seqBeats;
							beatNum <= beatNum + 3'd1;
						end
					end
				end
				seqBeats: begin	// Acks come back to back
					if (ack_i) begin
						beatNum <= beatNum + 3'd1;
						if (lastBeat) begin
							state   <= seqIdle;
							beatNum <= '0;
						end
					end
				end
				default: state <= seqIdle;
			endcase
		end
	end

	// Payload of the granted burst
	always_ff @(posedge gpuClk) begin
		if (burst.grant) begin
			kindQ  <= burst.kind;
			sideQ  <= burst.sideR;
			baseQ  <= burst.baseAdr;
			beatsQ <= burst.beats;
			pixLQ  <= burst.pixL;
			pixRQ  <= burst.pixR;
			selQ   <= burst.pairSel;
		end
	end

	// Bus side
	assign req_o  = ~burst.idle;
	assign busy_o = ~burst.idle;	// Whole operation, through last ack
	assign adr_o  = baseQ + busAdrT'(beatNum * beatBytes);	// Word per beat
	assign cnt_o  = beatsQ;
	assign wrt_o  = req_o & isWrite;
	assign dat_o  = {pixRQ, pixLQ};	// Right pixel in upper half
	assign sel_o  = selQ;

	// Read beats out to the router
	assign beat.beatValid = ack_i & req_o & ~isWrite;
	assign beat.kind      = kindQ;
	assign beat.sideR     = sideQ;
	assign beat.baseAdr   = baseQ;
	assign beat.beatIdx   = beatNum;
	assign beat.lastBeat  = lastBeat;
	assign beat.data      = dat_i;

endmodule

`default_nettype wire

// ==== source/cacheFillRouter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheFillRouter import gpuMemPkg::*; (
	input  logic       gpuClk,
	input  logic       resetX,
	beatIf.router      beat,
	output logic       texWrite_o,
	output texLineAdrT texWriteAdr_o,
	output texDataT    texData_o,
	output logic       texDoneL_o,
	output logic       texDoneR_o,
	output logic       clutWrite_o,
	output clutIndexT  clutIndex_o,
	output busDataT    clutData_o,
	output logic       clutDoneL_o,
	output logic       clutDoneR_o
);

	busDataT texLowQ;	// First texture beat
	logic    texBeat;
	logic    clutBeat;
	logic    texLast;
	logic    clutLast;

	assign texBeat  = beat.beatValid && (beat.kind == kindTex);
	assign clutBeat = beat.beatValid && (beat.kind == kindClut);
	assign texLast  = texBeat & beat.lastBeat;
	assign clutLast = clutBeat & beat.lastBeat;

	// Strobes and done pulses, one cycle after the ack
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			texWrite_o  <= 1'b0;
			texDoneL_o  <= 1'b0;
			texDoneR_o  <= 1'b0;
			clutWrite_o <= 1'b0;
			clutDoneL_o <= 1'b0;
			clutDoneR_o <= 1'b0;
		end else begin
			texWrite_o  <= texLast;	// Whole line at once
			texDoneL_o  <= texLast & ~beat.sideR;
			texDoneR_o  <= texLast & beat.sideR;
			clutWrite_o <= clutBeat;	// Every CLUT beat
			clutDoneL_o <= clutLast & ~beat.sideR;
			clutDoneR_o <= clutLast & beat.sideR;
		end
	end

	// Data paths
	always_ff @(posedge gpuClk) begin
		if (texBeat && beat.beatIdx == '0) begin
			texLowQ <= beat.data;
		end
		if (texLast) begin
			texData_o     <= {beat.data, texLowQ};	// Second beat high
			texWriteAdr_o <= texLineAdrT'(beat.baseAdr >> texLineShift);
		end
		if (clutBeat) begin
			clutIndex_o <= beat.beatIdx;
			clutData_o  <= beat.data;
		end
	end

endmodule

`default_nettype wire

// ==== source/memArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiter import gpuMemPkg::*; (
	input  logic         gpuClk,
	input  logic         resetX,
	// Command port
	input  memCmdT       memCmd_i,
	output logic         cmdReady_o,
	// Texture cache refill
	input  logic         texReqL_i,
	input  texLineAdrT   texAdrL_i,
	input  logic         texReqR_i,
	input  texLineAdrT   texAdrR_i,
	output logic         texDoneL_o,
	output logic         texDoneR_o,
	output logic         texWrite_o,
	output texLineAdrT   texWriteAdr_o,
	output texDataT      texData_o,
	// CLUT cache refill
	input  logic         clutReqL_i,
	input  clutBlockAdrT clutAdrL_i,
	input  logic         clutReqR_i,
	input  clutBlockAdrT clutAdrR_i,
	output logic         clutDoneL_o,
	output logic         clutDoneR_o,
	output logic         clutWrite_o,
	output clutIndexT    clutIndex_o,
	output busDataT      clutData_o,
	output logic         busy_o,
	// VRAM burst bus
	output logic         req_o,
	output busAdrT       adr_o,
	output beatCntT      cnt_o,
	output logic         wrt_o,
	output busDataT      dat_o,
	output beatSelT      sel_o,
	input  logic         ack_i,
	input  busDataT      dat_i
);

	burstIf burst ();	// Picker to sequencer
	beatIf  beat ();	// Sequencer to router

	requestPicker uPicker (
		.gpuClk     (gpuClk),
		.resetX     (resetX),
		.memCmd_i   (memCmd_i),
		.texReqL_i  (texReqL_i),
		.texAdrL_i  (texAdrL_i),
		.texReqR_i  (texReqR_i),
		.texAdrR_i  (texAdrR_i),
		.clutReqL_i (clutReqL_i),
		.clutAdrL_i (clutAdrL_i),
		.clutReqR_i (clutReqR_i),
		.clutAdrR_i (clutAdrR_i),
		.cmdReady_o (cmdReady_o),
		.burst      (burst.picker)
	);

	burstSequencer uSequencer (
		.gpuClk (gpuClk),
		.resetX (resetX),
		.burst  (burst.seq),
		.beat   (beat.seq),
		.req_o  (req_o),
		.adr_o  (adr_o),
		.cnt_o  (cnt_o),
		.wrt_o  (wrt_o),
		.dat_o  (dat_o),
		.sel_o  (sel_o),
		.ack_i  (ack_i),
		.dat_i  (dat_i),
		.busy_o (busy_o)
	);

	cacheFillRouter uRouter (
		.gpuClk        (gpuClk),
		.resetX        (resetX),
		.beat          (beat.router),
		.texWrite_o    (texWrite_o),
		.texWriteAdr_o (texWriteAdr_o),
		.texData_o     (texData_o),
		.texDoneL_o    (texDoneL_o),
		.texDoneR_o    (texDoneR_o),
		.clutWrite_o   (clutWrite_o),
		.clutIndex_o   (clutIndex_o),
		.clutData_o    (clutData_o),
		.clutDoneL_o   (clutDoneL_o),
		.clutDoneR_o   (clutDoneR_o)
	);

endmodule

`default_nettype wire

// ==== verification/memArbiter_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiterProps (
	input logic gpuClk,
	input logic resetX,
	input logic req_o,
	input logic ack_i,
	input logic texWrite_o,
	input logic clutWrite_o,
	input logic texDoneL_o,
	input logic texDoneR_o,
	input logic clutDoneL_o,
	input logic clutDoneR_o
);

	// Request holds while the slave stalls
	reqHold: assert property (@(posedge gpuClk) disable iff (resetX)
		req_o && !ack_i |=> req_o) else $error("req_o dropped before its beats");

	// Done pulses are single cycle
	texDoneOne: assert property (@(posedge gpuClk) disable iff (resetX)
		(texDoneL_o || texDoneR_o) |=> !(texDoneL_o || texDoneR_o))
		else $error("texture done pulse longer than one cycle");
	clutDoneOne: assert property (@(posedge gpuClk) disable iff (resetX)
		(clutDoneL_o || clutDoneR_o) |=> !(clutDoneL_o || clutDoneR_o))
		else $error("CLUT done pulse longer than one cycle");

	writeExcl: assert property (@(posedge gpuClk) disable iff (resetX)
		!(texWrite_o && clutWrite_o)) else $error("texture and CLUT write together");

endmodule

bind memArbiter memArbiterProps uProps (.*);

`default_nettype wire

// ==== verification/memArbiterChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiterChecker import gpuMemPkg::*; (
	input  logic         gpuClk,
	input  logic         resetX,
	input  logic         expPush_i,	// One expected burst per cycle
	input  logic [61:0]  expWord_i,	// Kind, side, base, cnt, data, enables
	input  logic         testEnd_i,
	input  logic [7:0]   testId_i,
	input  logic         report_i,
	output int           failCount_o,
	output busDataT      memData_o,
	input  logic         cmdReady_i,
	input  logic         busy_i,
	input  logic         req_i,
	input  busAdrT       adr_i,
	input  beatCntT      cnt_i,
	input  logic         wrt_i,
	input  busDataT      busDat_i,
	input  beatSelT      sel_i,
	input  logic         ack_i,
	input  logic         texWrite_i,
	input  texLineAdrT   texWriteAdr_i,
	input  texDataT      texData_i,
	input  logic         texDoneL_i,
	input  logic         texDoneR_i,
	input  logic         clutWrite_i,
	input  clutIndexT    clutIndex_i,
	input  busDataT      clutData_i,
	input  logic         clutDoneL_i,
	input  logic         clutDoneR_i
);

	logic [61:0] expQ[$];	// Bursts in expected order
	logic [1:0]  curKind;
	logic        curSide;
	busAdrT      curBase;
	beatCntT     curCnt;
	busDataT     curDat;
	beatSelT     curSel;
	logic        active;
	logic        stray;	// Burst with nothing expected
	beatCntT     beatNo;
	logic        pendClut, pendClutLast, pendTex;
	clutIndexT   expIdx;
	busDataT     expClutData, texLow, word;
	texDataT     expTex;
	busAdrT      beatAdr;
	int          testErr, passCount, failCount;

	// Reference VRAM contents depend on every address bit
	function automatic busDataT memWord(input busAdrT a);
		return {a[11:0], a} ^ 32'h5A3C96E1;
	endfunction

	function automatic string testName(input logic [7:0] id);
		case (id)
			8'd0: return "reset";
			8'd1: return "texture left";
			8'd2: return "texture right";
			8'd3: return "CLUT right";
			8'd4: return "block fill";
			8'd5: return "pixel pair";
			default: return "priority";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expV,
		input logic [63:0] gotV);
		if (expV !== gotV) begin
			$display("Error at %0t: %s expected %h got %h", $time, name, expV, gotV);
			testErr++;
		end
	endtask

	assign memData_o   = memWord(adr_i);	// Slave read data
	assign failCount_o = failCount;

	initial begin
		passCount = 0;
		failCount = 0;
		testErr   = 0;
	end

	always @(posedge gpuClk) begin
		if (resetX) begin
			active       = 1'b0;
			stray        = 1'b0;
			pendClut     = 1'b0;
			pendClutLast = 1'b0;
			pendTex      = 1'b0;
			beatNo       = '0;
			expQ.delete();
		end else begin
			if (expPush_i) expQ.push_back(expWord_i);
			// -------------------------------------------------------------------------
			// Cache side strobes come one cycle after their ack
			// -------------------------------------------------------------------------
			checkValue("clutWrite_o", 64'(pendClut), 64'(clutWrite_i));
			if (pendClut) begin
				checkValue("clutIndex_o", 64'(expIdx), 64'(clutIndex_i));
				checkValue("clutData_o", 64'(expClutData), 64'(clutData_i));
			end
			checkValue("clutDoneL_o", 64'(pendClutLast & ~curSide), 64'(clutDoneL_i));
			checkValue("clutDoneR_o", 64'(pendClutLast & curSide), 64'(clutDoneR_i));
			checkValue("texWrite_o", 64'(pendTex), 64'(texWrite_i));
			if (pendTex) begin
				checkValue("texData_o", expTex, texData_i);
				checkValue("texWriteAdr_o", 64'(curBase[19:3]), 64'(texWriteAdr_i));
			end
			checkValue("texDoneL_o", 64'(pendTex & ~curSide), 64'(texDoneL_i));
			checkValue("texDoneR_o", 64'(pendTex & curSide), 64'(texDoneR_i));
			pendClut     = 1'b0;
			pendClutLast = 1'b0;
			pendTex      = 1'b0;

			// Bus side
			checkValue("busy_o", 64'(active | req_i), 64'(busy_i));
			if (!req_i) stray = 1'b0;
			if (req_i && !active && !stray) begin
				if (expQ.size() == 0) begin
					$display("Bus burst at %0t with no request waiting for it", $time);
					testErr++;
					stray = 1'b1;
				end else begin
					{curKind, curSide, curBase, curCnt, curDat, curSel} = expQ.pop_front();
					active = 1'b1;
					beatNo = '0;
				end
			end
			if (active) begin
				checkValue("req_o", 64'd1, 64'(req_i));
				checkValue("cmdReady_o", 64'd0, 64'(cmdReady_i));
				checkValue("cnt_o", 64'(curCnt), 64'(cnt_i));
				checkValue("wrt_o", 64'(curKind == kindFill || curKind == kindPixelPair),
					64'(wrt_i));
				if (ack_i) begin
					beatAdr = curBase + {15'd0, beatNo, 2'b00};	// Word per beat
					checkValue("adr_o", 64'(beatAdr), 64'(adr_i));
					word = memWord(beatAdr);
					if (curKind == kindFill || curKind == kindPixelPair) begin
						checkValue("dat_o", 64'(curDat), 64'(busDat_i));
						checkValue("sel_o", 64'(curSel), 64'(sel_i));
					end else if (curKind == kindClut) begin
						pendClut     = 1'b1;
						pendClutLast = beatNo == curCnt;
						expIdx       = beatNo;
						expClutData  = word;
					end else if (beatNo == '0) begin
						texLow = word;
					end else begin
						pendTex = 1'b1;
						expTex  = {word, texLow};	// Second beat high
					end
					if (beatNo == curCnt) active = 1'b0;
					else beatNo = beatNo + 3'd1;
				end
			end else if (!req_i) begin
				checkValue("wrt_o", 64'd0, 64'(wrt_i));
			end

			if (testEnd_i) begin
				if (active || expQ.size() != 0) begin
					$display("Expected burst never completed in test %0d", testId_i);
					testErr++;
				end
				if (testErr == 0) begin
					$display("Test %0d %s: passed", testId_i, testName(testId_i));
					passCount++;
				end else begin
					$display("Test %0d %s: failed with %0d errors", testId_i,
						testName(testId_i), testErr);
					failCount++;
				end
				testErr = 0;
			end
			if (report_i) $display("Tests passed %0d, failed %0d", passCount, failCount);
		end
	end

endmodule

`default_nettype wire

// ==== verification/memArbiterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memArbiterTb import gpuMemPkg::*; ;

	logic gpuClk = 1'b0;
	logic resetX = 1'b1;
	memCmdT memCmd_i = '0;
	logic texReqL_i = 1'b0, texReqR_i = 1'b0, clutReqL_i = 1'b0, clutReqR_i = 1'b0;
	texLineAdrT texAdrL_i = '0, texAdrR_i = '0;
	clutBlockAdrT clutAdrL_i = '0, clutAdrR_i = '0;
	logic ack_i = 1'b0;
	busDataT dat_i;
	logic cmdReady_o, texDoneL_o, texDoneR_o, texWrite_o, clutDoneL_o, clutDoneR_o;
	logic clutWrite_o, busy_o, req_o, wrt_o;
	texLineAdrT texWriteAdr_o;
	texDataT texData_o;
	clutIndexT clutIndex_o;
	busDataT clutData_o, dat_o, memData;
	busAdrT adr_o;
	beatCntT cnt_o;
	beatSelT sel_o;

	logic expPush = 1'b0, testEnd = 1'b0, report = 1'b0;
	logic [61:0] expWord = '0;
	logic [7:0] testId = '0;
	int failCount;
	logic [31:0] rngStim = 32'd29449;
	logic [31:0] rngAck;
	logic [1:0] slvState = 2'd0;	// 0 idle, 1 delay, 2 acking
	logic [1:0] delayLeft;
	beatCntT ackLeft;
	texLineAdrT tA, tB;
	clutBlockAdrT cA, cB;
	blockAdrT blk;
	pixelT pL, pR;

	always #5 gpuClk = ~gpuClk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic memCmdT makeCmd(input cmdOpT op, input logic [2:0] pair,
		input blockAdrT b, input logic [1:0] valid, input pixelT pixR, input pixelT pixL);
		return {pixL, pixR, valid, b, pair, 1'b0, op};
	endfunction

	// ---------------------------------------------------------------------------
	// VRAM slave with a random stall then back to back acks
	// ---------------------------------------------------------------------------
	initial rngAck = xorshift(32'd29449);
	assign dat_i = memData;	// Read data follows the beat address

	always @(posedge gpuClk) begin
		if (resetX) begin
			slvState <= 2'd0;
			ack_i    <= 1'b0;
		end else if (slvState == 2'd0 && req_o) begin
			rngAck = xorshift(rngAck);
			if (rngAck[1:0] == 2'd0) begin
				ack_i    <= 1'b1;
				ackLeft  <= cnt_o;
				slvState <= 2'd2;
			end else begin
				delayLeft <= rngAck[1:0];
				slvState  <= 2'd1;
			end
		end else if (slvState == 2'd1) begin
			if (delayLeft == 2'd1) begin
				ack_i    <= 1'b1;
				ackLeft  <= cnt_o;
				slvState <= 2'd2;
			end else delayLeft <= delayLeft - 2'd1;
		end else if (slvState == 2'd2) begin
			if (ackLeft == '0) begin
				ack_i    <= 1'b0;
				slvState <= 2'd0;
			end else ackLeft <= ackLeft - 3'd1;
		end
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic pushExpect(input burstKindT kind, input logic side, input busAdrT base,
		input beatCntT cnt, input busDataT dat, input beatSelT sel);
		expWord <= {kind, side, base, cnt, dat, sel};
		expPush <= 1'b1;
		@(posedge gpuClk);
		expPush <= 1'b0;
	endtask

	// Command held until the picker takes it
	task automatic sendCmd(input memCmdT cmd);
		int n;
		memCmd_i <= cmd;
		for (n = 0; n < 50; n++) begin
			@(posedge gpuClk);
			if (cmdReady_o) break;
		end
		memCmd_i <= '0;
		if (n == 50) abortRun("Timeout, command never accepted");
	endtask

	// Requesters drop on their done pulse
	task automatic waitQuiet();
		int n;
		for (n = 0; n < 400; n++) begin
			@(posedge gpuClk);
			if (texDoneL_o) texReqL_i <= 1'b0;
			if (texDoneR_o) texReqR_i <= 1'b0;
			if (clutDoneL_o) clutReqL_i <= 1'b0;
			if (clutDoneR_o) clutReqR_i <= 1'b0;
			if (!(texReqL_i | texReqR_i | clutReqL_i | clutReqR_i) && memCmd_i == '0 &&
				cmdReady_o && !req_o) break;
		end
		if (n == 400) abortRun("Timeout, requests still pending");
	endtask

	task automatic endTest(input logic [7:0] id);
		testId  <= id;
		testEnd <= 1'b1;
		@(posedge gpuClk);
		testEnd <= 1'b0;
	endtask

	task automatic pickRandoms();
		rngStim = xorshift(rngStim);
		tA = rngStim[16:0];
		cA = rngStim[31:17];
		rngStim = xorshift(rngStim);
		tB = rngStim[16:0];
		cB = rngStim[31:17];
		rngStim = xorshift(rngStim);
		blk = rngStim[14:0];
		pL  = rngStim[31:16];
		rngStim = xorshift(rngStim);
		pR  = rngStim[15:0];
	endtask

	initial begin
		repeat (2) @(posedge gpuClk);
		resetX <= 1'b0;
		repeat (3) @(posedge gpuClk);
		endTest(8'd0);
		pickRandoms();
		pushExpect(kindTex, 1'b0, {tA, 3'b000}, 3'd1, '0, '0);
		texAdrL_i <= tA;
		texReqL_i <= 1'b1;
		waitQuiet();
		endTest(8'd1);
		pushExpect(kindTex, 1'b1, {tB, 3'b000}, 3'd1, '0, '0);
		texAdrR_i <= tB;
		texReqR_i <= 1'b1;
		waitQuiet();
		endTest(8'd2);
		pushExpect(kindClut, 1'b1, {cB, 5'd0}, 3'd7, '0, '0);
		clutAdrR_i <= cB;
		clutReqR_i <= 1'b1;
		waitQuiet();
		endTest(8'd3);
		pushExpect(kindFill, 1'b0, {blk, 5'd0}, 3'd7, {pL, pL}, 4'hF);
		sendCmd(makeCmd(cmdFill, 3'd0, blk, 2'b00, pR, pL));
		waitQuiet();
		endTest(8'd4);
		pushExpect(kindPixelPair, 1'b0, {blk, 3'd5, 2'b00}, 3'd0, {pR, pL}, 4'b1100);
		sendCmd(makeCmd(cmdPixelPair, 3'd5, blk, 2'b10, pR, pL));
		waitQuiet();
		endTest(8'd5);
		// Everyone at once gets served in strict priority
		pickRandoms();
		pushExpect(kindPixelPair, 1'b0, {blk, 3'd2, 2'b00}, 3'd0, {pR, pL}, 4'hF);
		pushExpect(kindClut, 1'b0, {cA, 5'd0}, 3'd7, '0, '0);
		pushExpect(kindClut, 1'b1, {cB, 5'd0}, 3'd7, '0, '0);
		pushExpect(kindTex, 1'b0, {tA, 3'b000}, 3'd1, '0, '0);
		pushExpect(kindTex, 1'b1, {tB, 3'b000}, 3'd1, '0, '0);
		{clutAdrL_i, clutAdrR_i, texAdrL_i, texAdrR_i} <= {cA, cB, tA, tB};
		{clutReqL_i, clutReqR_i, texReqL_i, texReqR_i} <= 4'hF;
		sendCmd(makeCmd(cmdPixelPair, 3'd2, blk, 2'b11, pR, pL));
		waitQuiet();
		endTest(8'd6);
		report <= 1'b1;
		@(posedge gpuClk);
		report <= 1'b0;
		@(posedge gpuClk);
		if (failCount == 0) $display(">>> PASS");
		else $display(">>> FAIL");
		$finish;
	end

	memArbiter u_dut (.*);

	memArbiterChecker uCheck (
		.gpuClk(gpuClk), .resetX(resetX), .expPush_i(expPush), .expWord_i(expWord),
		.testEnd_i(testEnd), .testId_i(testId), .report_i(report),
		.failCount_o(failCount), .memData_o(memData),
		.cmdReady_i(cmdReady_o), .busy_i(busy_o), .req_i(req_o), .adr_i(adr_o),
		.cnt_i(cnt_o), .wrt_i(wrt_o), .busDat_i(dat_o), .sel_i(sel_o), .ack_i(ack_i),
		.texWrite_i(texWrite_o), .texWriteAdr_i(texWriteAdr_o), .texData_i(texData_o),
		.texDoneL_i(texDoneL_o), .texDoneR_i(texDoneR_o), .clutWrite_i(clutWrite_o),
		.clutIndex_i(clutIndex_o), .clutData_i(clutData_o),
		.clutDoneL_i(clutDoneL_o), .clutDoneR_i(clutDoneR_o)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
source/gpuMemPkg.sv
source/burstIf.sv
source/beatIf.sv
source/requestPicker.sv
source/burstSequencer.sv
source/cacheFillRouter.sv
source/memArbiter.sv
verification/memArbiter_props.sv
verification/memArbiterChecker.sv
verification/memArbiterTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memArbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module memArbiterTb \
	-f tb.f --Mdir obj_dir -o simv > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1
grep -qxF ">>> PASS" sim.log && { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
